/* dot_matrix_countdown.f */
+incdir+include
hw/dot_matrix_pkg.sv
hw/countdown_timer.sv
hw/glyph_frame_buffer.sv
hw/matrix_row_scanner.sv
hw/dot_matrix_top.sv
bench/dot_matrix_asserts.sv
bench/dot_matrix_tb.sv

/* Bender.yml */
package:
  name: dot_matrix_countdown

export_include_dirs:
  - include

sources:
  - files:
      - hw/dot_matrix_pkg.sv
      - hw/countdown_timer.sv
      - hw/glyph_frame_buffer.sv
      - hw/matrix_row_scanner.sv
      - hw/dot_matrix_top.sv

  - target: test
    files:
      - bench/dot_matrix_asserts.sv
      - bench/dot_matrix_tb.sv

/* bench/dot_matrix_tb.sv */
`timescale 1ns/10ps
`include "dot_matrix_params.svh"

module dot_matrix_tb;

    import dot_matrix_pkg::*;

    localparam int N          = `MATRIX_ROWS;
    localparam int FRAME_CLKS = N * `SCAN_DIV;
    localparam int SHOW_LIMIT = 4 * FRAME_CLKS;

    logic         clk;
    logic         rst;
    logic         start;
    logic [2:0]   start_digit;
    logic [N-1:0] row;
    logic [N-1:0] colr;
    logic [N-1:0] colg;

    logic [15:0]    lfsr;
    int             num_checks;
    int             num_errors;
    int             errors_mark;
    int             test_num;
    int             cycle;
    int             step_mark;
    glyph_sel_t     exp_glyph;
    glyph_sel_t     old_glyph;
    logic           changing;
    int             stale_frames;
    int             frames_seen;
    logic [N-1:0]   prev_row;
    logic [N-1:0]   run_r;
    logic [N-1:0]   run_g;
    int             run_len;
    int             rows_got;
    logic [N*N-1:0] frm_r;
    logic [N*N-1:0] frm_g;

    dot_matrix_top uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .start_digit (start_digit),
        .row         (row),
        .colr        (colr),
        .colg        (colg)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    // expected colr and colg for one glyph row with bit 7 leftmost
    function automatic logic [15:0] ref_cols(input glyph_sel_t g, input int r);
        logic [63:0] art;
        logic [7:0]  bits;
        case (g)
            glyph_one:   art = 64'h001838181818183C;
            glyph_two:   art = 64'h003C66060C30607E;
            glyph_three: art = 64'h003C66061C06663C;
            glyph_four:  art = 64'h000C1C2C4C7E0C0C;
            glyph_done:  art = 64'hFF818181818181FF;
            default:     art = 64'h0;
        endcase
        bits = art[63-8*r -: 8];
        if (g == glyph_done)
            ref_cols = {8'h00, bits}; // green only
        else
            ref_cols = {bits, 8'h00};
    endfunction

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    function automatic int take_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            val  = (val << 1) | lfsr[0];
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        num_checks++;
        if (got !== exp)
        begin
            num_errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        num_errors++;
        $display("timeout while waiting for %s at %0t ns", what, $time);
    endtask

    task automatic build_frame(input glyph_sel_t g, output logic [N*N-1:0] fr,
                               output logic [N*N-1:0] fg);
        logic [15:0] cols;
        for (int r = 0; r < N; r++)
        begin
            cols = ref_cols(g, r);
            fr[N*N-1-N*r -: N] = cols[15:8];
            fg[N*N-1-N*r -: N] = cols[7:0];
        end
    endtask

    task automatic judge_frame();
        logic [N*N-1:0] exp_r;
        logic [N*N-1:0] exp_g;
        logic [N*N-1:0] old_r;
        logic [N*N-1:0] old_g;
        build_frame(exp_glyph, exp_r, exp_g);
        build_frame(old_glyph, old_r, old_g);
        if (changing && stale_frames < 2 && frm_r == old_r && frm_g == old_g)
            stale_frames++; // swap not reached yet
        else
        begin
            check_value("colr frame", frm_r, exp_r);
            check_value("colg frame", frm_g, exp_g);
            changing = 1'b0;
        end
        frames_seen++;
    endtask

    // frame assembly from the pins just after each rising edge
    always
    begin
        @(posedge clk);
        #1;
        if (rst)
        begin
            run_len  = 0;
            rows_got = 0;
        end
        else if (run_len != 0 && row == prev_row)
        begin
            run_len++;
            check_value("colr", colr, run_r);
            check_value("colg", colg, run_g);
        end
        else
        begin
            if (run_len != 0)
            begin
                check_value("row", row, {prev_row[N-2:0], prev_row[N-1]});
                check_value("row hold", run_len, `SCAN_DIV);
                if (rows_got == N)
                    judge_frame();
            end
            if (row == {{(N-1){1'b1}}, 1'b0})
                rows_got = 0;
            if (rows_got < N && row == ~(N'(1) << rows_got))
            begin
                frm_r[N*N-1-N*rows_got -: N] = colr;
                frm_g[N*N-1-N*rows_got -: N] = colg;
                rows_got++;
            end
            else
                rows_got = 0;
            prev_row = row;
            run_len  = 1;
            run_r    = colr;
            run_g    = colg;
        end
    end

    task automatic set_expect(input glyph_sel_t g);
        if (g != exp_glyph)
        begin
            old_glyph    = exp_glyph;
            exp_glyph    = g;
            changing     = 1'b1;
            stale_frames = 0;
        end
    endtask

    task automatic pulse_start(input logic [2:0] d);
        start       = 1'b1;
        start_digit = d;
        if (d >= 3'd1 && d <= 3'(`MAX_START))
        begin
            step_mark = cycle;
            set_expect(glyph_sel_t'(d));
        end
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        int waited;
        target = frames_seen + n;
        waited = 0;
        while (frames_seen < target && waited < (n + 1) * FRAME_CLKS + 8)
        begin
            @(negedge clk);
            waited++;
        end
        if (frames_seen < target)
            report_timeout("complete frames");
    endtask

    task automatic wait_shown();
        int waited;
        waited = 0;
        while (changing && waited < SHOW_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (changing)
            report_timeout("the new glyph on the matrix");
    endtask

    task automatic wait_cycle(input int target);
        int waited;
        waited = 0;
        while (cycle < target && waited < `STEP_CYCLES + 8)
        begin
            @(negedge clk);
            waited++;
        end
        if (cycle < target)
            report_timeout("the countdown step");
    endtask

    // digit one is followed by done
    task automatic follow_count(input int from_digit);
        for (int g = from_digit; g >= 1; g--)
        begin
            wait_cycle(step_mark + `STEP_CYCLES);
            step_mark = step_mark + `STEP_CYCLES;
            set_expect((g == 1) ? glyph_done : glyph_sel_t'(g - 1));
            wait_shown();
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, num_errors - errors_mark);
        errors_mark = num_errors;
    endtask

    initial
    begin
        logic [2:0] digit;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b0;
        start_digit  = 3'd0;
        lfsr         = 16'd61931;
        num_checks   = 0;
        num_errors   = 0;
        errors_mark  = 0;
        test_num     = 0;
        cycle        = 0;
        step_mark    = 0;
        exp_glyph    = glyph_blank;
        old_glyph    = glyph_blank;
        changing     = 1'b0;
        stale_frames = 0;
        frames_seen  = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        wait_frames(3);
        end_test("blank scan after reset");

        digit = 3'(take_bits(2) + 1);
        pulse_start(digit);
        wait_shown();
        wait_frames(1);
        end_test("random start digit");

        follow_count(digit);
        wait_frames(3); // done frame must hold
        end_test("countdown to done");

        for (int i = 0; i < 4; i++)
        begin
            digit = (i == 0) ? 3'd0 : 3'(i + 4);
            pulse_start(digit);
            wait_frames(1);
        end
        wait_frames(`STEP_CYCLES / FRAME_CLKS + 3); // a wrongly started count would step
        end_test("out of range digits ignored");

        pulse_start(3'd4);
        wait_shown();
        digit = 3'(take_bits(2) + 1);
        pulse_start(digit);
        wait_shown();
        follow_count(digit);
        wait_frames(1);
        end_test("restart during count");

        digit = 3'(take_bits(2) + 1);
        pulse_start(digit);
        wait_shown();
        follow_count(digit);
        wait_frames(2);
        end_test("start after done");

        num_errors = num_errors + uut.u_asserts.assert_failures;
        $display("%0d checks, %0d errors", num_checks, num_errors);
        if (num_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* bench/dot_matrix_asserts.sv */
`timescale 1ns/10ps
`include "dot_matrix_params.svh"

module dot_matrix_asserts (
    input logic                         clk,
    input logic                         rst,
    input logic [`MATRIX_ROWS-1:0]      row,
    input logic [`MATRIX_ROWS-1:0]      colr,
    input logic [`MATRIX_ROWS-1:0]      colg,
    input logic                         glyph_strobe,
    input dot_matrix_pkg::timer_state_t state
);

    import dot_matrix_pkg::*;

    int assert_failures;

    initial
        assert_failures = 0;

    // exactly one row pulled low
    row_one_hot_low: assert property (@(posedge clk) disable iff (rst) $onehot(~row))
        else
        begin
            $error("row select is not one-hot low");
            assert_failures++;
        end

    colours_exclusive: assert property (@(posedge clk) disable iff (rst)
        !((|colr) && (|colg)))
        else
        begin
            $error("red and green columns driven together");
            assert_failures++;
        end

    strobe_single: assert property (@(posedge clk) disable iff (rst)
        glyph_strobe |=> !glyph_strobe)
        else
        begin
            $error("glyph strobe longer than one cycle");
            assert_failures++;
        end

    state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {st_idle, st_count, st_done})
        else
        begin
            $error("timer FSM in an illegal state");
            assert_failures++;
        end

endmodule

bind dot_matrix_top dot_matrix_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .row          (row),
    .colr         (colr),
    .colg         (colg),
    .glyph_strobe (glyph_strobe),
    .state        (u_timer.state)
);

/* hw/dot_matrix_top.sv */
`timescale 1ns/10ps
`include "dot_matrix_params.svh"

module dot_matrix_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic [2:0]              start_digit,
    output logic [`MATRIX_ROWS-1:0] row,
    output logic [`MATRIX_ROWS-1:0] colr,
    output logic [`MATRIX_ROWS-1:0] colg
);

    import dot_matrix_pkg::*;

    glyph_sel_t                       glyph_sel;
    logic                             glyph_strobe;
    logic                             frame_end;
    logic [$clog2(`MATRIX_ROWS)-1:0]  row_index;
    logic [`MATRIX_ROWS-1:0]          row_pattern;
    colour_t                          row_colour;

    countdown_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .start_digit  (start_digit),
        .glyph_sel    (glyph_sel),
        .glyph_strobe (glyph_strobe)
    );

    glyph_frame_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .glyph_sel    (glyph_sel),
        .glyph_strobe (glyph_strobe),
        .frame_end    (frame_end),
        .row_index    (row_index),
        .row_pattern  (row_pattern),
        .row_colour   (row_colour)
    );

    matrix_row_scanner u_scanner (
        .clk          (clk),
        .rst          (rst),
        .row_pattern  (row_pattern),
        .row_colour   (row_colour),
        .row_index    (row_index),
        .frame_end    (frame_end),
        .row          (row),
        .colr         (colr),
        .colg         (colg)
    );

endmodule

/* hw/matrix_row_scanner.sv */
`timescale 1ns/10ps
`include "dot_matrix_params.svh"

module matrix_row_scanner (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [`MATRIX_ROWS-1:0]          row_pattern,
    input  dot_matrix_pkg::colour_t          row_colour,
    output logic [$clog2(`MATRIX_ROWS)-1:0]  row_index,
    output logic                             frame_end,
    output logic [`MATRIX_ROWS-1:0]          row,
    output logic [`MATRIX_ROWS-1:0]          colr,
    output logic [`MATRIX_ROWS-1:0]          colg
);

    import dot_matrix_pkg::*;

    localparam int ROW_W = $clog2(`MATRIX_ROWS);
    localparam int DIV_W = $clog2(`SCAN_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCAN_DIV - 1);
    localparam logic [ROW_W-1:0] ROW_LAST = ROW_W'(`MATRIX_ROWS - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             row_step;

    assign row_step  = (div_cnt == DIV_LAST);
    assign frame_end = row_step && (row_index == ROW_LAST); // last clock of row 7

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt   <= '0;
            row_index <= '0;
        end
        else if (row_step)
        begin
            div_cnt   <= '0;
            row_index <= row_index + 1'b1; // wraps 7 -> 0
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // pins lag row_index by one clock
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= {{(`MATRIX_ROWS-1){1'b1}}, 1'b0};
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= ~(`MATRIX_ROWS'(1) << row_index); // active low select
            colr <= (row_colour == colour_red) ? row_pattern : '0;
            colg <= (row_colour == colour_green) ? row_pattern : '0;
        end
    end

endmodule

/* hw/glyph_frame_buffer.sv */
`timescale 1ns/10ps
`include "dot_matrix_params.svh"

module glyph_frame_buffer (
    input  logic                             clk,
    input  logic                             rst,
    input  dot_matrix_pkg::glyph_sel_t       glyph_sel,
    input  logic                             glyph_strobe,
    input  logic                             frame_end,
    input  logic [$clog2(`MATRIX_ROWS)-1:0]  row_index,
    output logic [`MATRIX_ROWS-1:0]          row_pattern,
    output dot_matrix_pkg::colour_t          row_colour
);

    import dot_matrix_pkg::*;

    localparam int FRAME_W = `MATRIX_ROWS * `MATRIX_ROWS;

    logic [`MATRIX_ROWS-1:0] pend_rows [`MATRIX_ROWS];
    colour_t                 pend_colour;
    logic [`MATRIX_ROWS-1:0] disp_rows [`MATRIX_ROWS];
    colour_t                 disp_colour;
    logic [FRAME_W-1:0]      rom_frame;
    colour_t                 rom_colour;

    // glyph ROM, row 0 in the top byte, bit 7 leftmost column
    function automatic logic [FRAME_W-1:0] glyph_bits(input glyph_sel_t g);
        case (g)
            glyph_one:
                glyph_bits = 64'h00_18_38_18_18_18_18_3C;
            glyph_two:
                glyph_bits = 64'h00_3C_66_06_0C_30_60_7E;
            glyph_three:
                glyph_bits = 64'h00_3C_66_06_1C_06_66_3C;
            glyph_four:
                glyph_bits = 64'h00_0C_1C_2C_4C_7E_0C_0C;
            glyph_done:
                glyph_bits = 64'hFF_81_81_81_81_81_81_FF; // border box
            default:
                glyph_bits = '0; // blank
        endcase
    endfunction

    assign rom_frame  = glyph_bits(glyph_sel);
    assign rom_colour = (glyph_sel == glyph_done) ? colour_green : colour_red;

    // pending frame, loaded on a glyph change
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `MATRIX_ROWS; i++)
                pend_rows[i] <= '0;
            pend_colour <= colour_red;
        end
        else if (glyph_strobe)
        begin
            for (int i = 0; i < `MATRIX_ROWS; i++)
                pend_rows[i] <= rom_frame[FRAME_W-1-i*`MATRIX_ROWS -: `MATRIX_ROWS];
            pend_colour <= rom_colour;
        end
    end

    // displayed frame only moves at the frame boundary
    // on a coincident strobe the old pending frame is taken
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `MATRIX_ROWS; i++)
                disp_rows[i] <= '0;
            disp_colour <= colour_red;
        end
        else if (frame_end)
        begin
            for (int i = 0; i < `MATRIX_ROWS; i++)
                disp_rows[i] <= pend_rows[i];
            disp_colour <= pend_colour;
        end
    end

    assign row_pattern = disp_rows[row_index];
    assign row_colour  = disp_colour;

endmodule

/* hw/countdown_timer.sv */
`timescale 1ns/10ps
`include "dot_matrix_params.svh"

module countdown_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic [2:0]                 start_digit,
    output dot_matrix_pkg::glyph_sel_t glyph_sel,
    output logic                       glyph_strobe
);

    import dot_matrix_pkg::*;

    localparam int STEP_W = $clog2(`STEP_CYCLES);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`STEP_CYCLES - 1);
    localparam logic [2:0] DIGIT_MAX = 3'(`MAX_START);

    timer_state_t      state;
    timer_state_t      state_nxt;
    glyph_sel_t        glyph_nxt;
    logic [STEP_W-1:0] step_cnt;
    logic              start_ok;
    logic              step_done;

    // digits outside 1..MAX_START are dropped
    assign start_ok  = start && (start_digit != 3'd0) && (start_digit <= DIGIT_MAX);
    assign step_done = (state == st_count) && (step_cnt == STEP_LAST);

    always_comb
    begin
        logic [2:0] cur_code;
        cur_code  = glyph_sel;
        state_nxt = state;
        glyph_nxt = glyph_sel;
        if (start_ok)
        begin
            // accepted in any state, restarts a running count
            state_nxt = st_count;
            glyph_nxt = glyph_sel_t'(start_digit);
        end
        else if (step_done)
        begin
            if (glyph_sel == glyph_one)
            begin
                state_nxt = st_done;
                glyph_nxt = glyph_done;
            end
            else
            begin
                glyph_nxt = glyph_sel_t'(cur_code - 3'd1);
            end
        end
    end

    // step prescaler, only runs while counting
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            step_cnt <= '0;
        else if (start_ok || step_done || state != st_count)
            step_cnt <= '0;
        else
            step_cnt <= step_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= st_idle;
            glyph_sel    <= glyph_blank;
            glyph_strobe <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            glyph_sel    <= glyph_nxt;
            glyph_strobe <= (glyph_nxt != glyph_sel); // pulse on a real change only
        end
    end

endmodule

/* hw/dot_matrix_pkg.sv */
package dot_matrix_pkg;

    // countdown FSM states
    typedef enum logic [1:0]
    {
        st_idle  = 2'd0,
        st_count = 2'd1,
        st_done  = 2'd2
    } timer_state_t;

    // glyph selection
    // codes 1..4 equal the digit shown
    typedef enum logic [2:0]
    {
        glyph_blank = 3'd0,
        glyph_one   = 3'd1,
        glyph_two   = 3'd2,
        glyph_three = 3'd3,
        glyph_four  = 3'd4,
        glyph_done  = 3'd5
    } glyph_sel_t;

    // column colour of the two-colour matrix
    typedef enum logic
    {
        colour_red   = 1'b0,
        colour_green = 1'b1
    } colour_t;

endpackage

/* include/dot_matrix_params.svh */
`ifndef DOT_MATRIX_PARAMS_SVH
`define DOT_MATRIX_PARAMS_SVH

// matrix geometry
// rows and columns are the same size
`define MATRIX_ROWS 8

// display scan timing

// clocks each row stays lit
`define SCAN_DIV 4

// countdown timing

// clocks per digit
`define STEP_CYCLES 256

// accepted start digits run 1 .. MAX_START
`define MAX_START 4

// a full frame takes MATRIX_ROWS * SCAN_DIV clocks
// the glyph ROM is drawn for an 8x8 matrix

`endif
